// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = txdat_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+testbench
design/txdat_pkg.sv
design/txdat_line_buffer.sv
design/txdat_beat_fsm.sv
design/txdat_lcrd_counter.sv
design/txdat_flit_packer.sv
design/txdat_top.sv
testbench/txdat_tb.sv

// File: design/txdat_beat_fsm.sv
//------------------------------
// picks the next pending half of the head line, lower half first
// a beat goes out in any cycle with a head line and a credit
// line_pop marks the last pending beat of the head line
//------------------------------

`timescale 1ns/100ps

module txdat_beat_fsm
    import txdat_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  head_valid,
    input  pend_t head_pend,
    input  logic  crd_avail,
    output logic  beat_send,
    output logic  beat_upper,
    output logic  line_pop
);

    beat_state_t state;
    beat_state_t state_next;

    // idle serves a fresh head straight from its mask
    always_comb begin
        case (state)
            beat_low:  beat_upper = 1'b0;
            beat_high: beat_upper = 1'b1;
            default:   beat_upper = !head_pend[0];
        endcase
    end

    // a started line keeps its head until popped
    assign beat_send = crd_avail && (head_valid || (state != beat_idle));

    // upper half is always the last one
    assign line_pop = beat_send && (beat_upper || !head_pend[1]);

    always_comb begin
        state_next = state;
        case (state)
            beat_idle: begin
                if (beat_send) begin
                    if (!line_pop) begin
                        state_next = beat_high;
                    end
                end else if (head_valid) begin
                    state_next = head_pend[0] ? beat_low : beat_high;
                end
            end
            beat_low: begin
                if (beat_send) begin
                    state_next = line_pop ? beat_idle : beat_high;
                end
            end
            beat_high: begin
                if (beat_send) begin
                    state_next = beat_idle;
                end
            end
            default: state_next = beat_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= beat_idle;
        end else begin
            state <= state_next;
        end
    end

    // state must never outlive its head line
    assert property (@(posedge clk) disable iff (rst) beat_send |-> head_valid)
        else $error("beat sent without a head line");

endmodule

// File: design/txdat_flit_packer.sv
//------------------------------
// builds the data flit for the selected half and registers it
// flit keeps its last value between beats, only flitv is cleared
// homenid is filled for compdata only
//------------------------------

`timescale 1ns/100ps

module txdat_flit_packer
    import txdat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       beat_send,
    input  logic       beat_upper,
    input  node_id_t   head_tgtid,
    input  txn_id_t    head_txnid,
    input  opcode_t    head_opcode,
    input  resp_t      head_resp,
    input  resperr_t   head_resperr,
    input  txn_id_t    head_dbid,
    input  line_data_t head_data,
    input  line_be_t   head_be,
    output logic       flitv,
    output flit_t      flit
);

    flit_t flit_next;

    always_comb begin
        flit_next = '0;
        flit_next[flit_data_lsb +: beat_data_w] =
            beat_upper ? head_data[beat_data_w +: beat_data_w] : head_data[0 +: beat_data_w];
        flit_next[flit_be_lsb +: beat_be_w] =
            beat_upper ? head_be[beat_be_w +: beat_be_w] : head_be[0 +: beat_be_w];
        flit_next[flit_dataid_lsb +: dataid_w]   = beat_upper ? dataid_high : dataid_low;
        flit_next[flit_dbid_lsb +: txn_id_w]     = head_dbid;
        flit_next[flit_resp_lsb +: resp_w]       = head_resp;
        flit_next[flit_resperr_lsb +: resperr_w] = head_resperr;
        flit_next[flit_opcode_lsb +: opcode_w]   = head_opcode;
        flit_next[flit_homenid_lsb +: node_id_w] =
            (head_opcode == opcode_compdata) ? home_node_id : '0;
        flit_next[flit_txnid_lsb +: txn_id_w]    = head_txnid;
        flit_next[flit_srcid_lsb +: node_id_w]   = home_node_id;
        flit_next[flit_tgtid_lsb +: node_id_w]   = head_tgtid;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flitv <= 1'b0;
        end else begin
            flitv <= beat_send;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_send) begin
            flit <= flit_next;
        end
    end

endmodule

// File: design/txdat_lcrd_counter.sv
//------------------------------
// link credit counter
// a grant in the same cycle counts as available
// grant and send together leave the count unchanged
//------------------------------

`timescale 1ns/100ps

module txdat_lcrd_counter
    import txdat_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic lcrdv,
    input  logic beat_send,
    output logic crd_avail
);

    lcrd_cnt_t crd_cnt;

    assign crd_avail = (crd_cnt != '0) || lcrdv;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crd_cnt <= '0;
        end else if (lcrdv && !beat_send) begin
            crd_cnt <= crd_cnt + 1'b1;
        end else if (beat_send && !lcrdv) begin
            crd_cnt <= crd_cnt - 1'b1;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // link must not grant past the counter range
    assert property (@(posedge clk) disable iff (rst)
        (lcrdv && !beat_send) |-> (crd_cnt != max_lcrd))
        else $error("link credit count overflow");

    // sender must not spend a credit it does not hold
    assert property (@(posedge clk) disable iff (rst)
        (beat_send && !lcrdv) |-> (crd_cnt != '0))
        else $error("link credit count underflow");

endmodule

// File: design/txdat_line_buffer.sv
//------------------------------
// two-entry line store served oldest first
// line_ready is registered state and drops once both entries are held
// release report is registered on the pop edge
// line_pop must only come while a head line is present
//------------------------------

`timescale 1ns/100ps

module txdat_line_buffer
    import txdat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_valid,
    output logic       line_ready,
    input  buf_idx_t   line_idx,
    input  node_id_t   line_tgtid,
    input  txn_id_t    line_txnid,
    input  opcode_t    line_opcode,
    input  resp_t      line_resp,
    input  resperr_t   line_resperr,
    input  txn_id_t    line_dbid,
    input  line_data_t line_data,
    input  line_be_t   line_be,
    input  pend_t      line_pend,
    input  logic       line_pop,
    output logic       head_valid,
    output node_id_t   head_tgtid,
    output txn_id_t    head_txnid,
    output opcode_t    head_opcode,
    output resp_t      head_resp,
    output resperr_t   head_resperr,
    output txn_id_t    head_dbid,
    output line_data_t head_data,
    output line_be_t   head_be,
    output pend_t      head_pend,
    output logic       release_valid,
    output buf_idx_t   release_idx
);

    buf_idx_t   idx_mem     [2];
    node_id_t   tgtid_mem   [2];
    txn_id_t    txnid_mem   [2];
    opcode_t    opcode_mem  [2];
    resp_t      resp_mem    [2];
    resperr_t   resperr_mem [2];
    txn_id_t    dbid_mem    [2];
    line_data_t data_mem    [2];
    line_be_t   be_mem      [2];
    pend_t      pend_mem    [2];

    logic [1:0] count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;

    assign push       = line_valid && line_ready;
    assign line_ready = (count != 2'd2);
    assign head_valid = (count != 2'd0);

    // head is always the oldest entry
    assign head_tgtid   = tgtid_mem[rd_ptr];
    assign head_txnid   = txnid_mem[rd_ptr];
    assign head_opcode  = opcode_mem[rd_ptr];
    assign head_resp    = resp_mem[rd_ptr];
    assign head_resperr = resperr_mem[rd_ptr];
    assign head_dbid    = dbid_mem[rd_ptr];
    assign head_data    = data_mem[rd_ptr];
    assign head_be      = be_mem[rd_ptr];
    assign head_pend    = pend_mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count         <= 2'd0;
            wr_ptr        <= 1'b0;
            rd_ptr        <= 1'b0;
            release_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (line_pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, line_pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            release_valid <= line_pop;
        end
    end

    // entry storage and release index
    always_ff @(posedge clk) begin
        if (push) begin
            idx_mem[wr_ptr]     <= line_idx;
            tgtid_mem[wr_ptr]   <= line_tgtid;
            txnid_mem[wr_ptr]   <= line_txnid;
            opcode_mem[wr_ptr]  <= line_opcode;
            resp_mem[wr_ptr]    <= line_resp;
            resperr_mem[wr_ptr] <= line_resperr;
            dbid_mem[wr_ptr]    <= line_dbid;
            data_mem[wr_ptr]    <= line_data;
            be_mem[wr_ptr]      <= line_be;
            pend_mem[wr_ptr]    <= line_pend;
        end
        if (line_pop) begin
            release_idx <= idx_mem[rd_ptr];
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // producer holds a waiting line until it is taken
    assert property (@(posedge clk) disable iff (rst)
        (line_valid && !line_ready) |=>
            (line_valid && $stable(line_idx) && $stable(line_pend) && $stable(line_data)))
        else $error("waiting line dropped or changed before it was taken");

    assert property (@(posedge clk) disable iff (rst) line_pop |-> head_valid)
        else $error("line pop with empty buffer");

    assert property (@(posedge clk) disable iff (rst) push |-> line_pend != 2'b00)
        else $error("line pushed with empty pending mask");

endmodule

// File: design/txdat_pkg.sv
//------------------------------
// shared widths, flit layout and types for the txdat channel
// flit fields are packed from data at bit 0 up to tgtid at the top
// reserved, poison, datacheck, tag, trace and qos fields are not carried
// max_lcrd must fit in lcrd_cnt_w bits
//------------------------------

package txdat_pkg;

    // field widths
    localparam int node_id_w   = 7;
    localparam int txn_id_w    = 12;
    localparam int opcode_w    = 4;
    localparam int resp_w      = 3;
    localparam int resperr_w   = 2;
    localparam int dataid_w    = 2;
    localparam int beat_data_w = 128;
    localparam int beat_be_w   = 16;
    localparam int line_data_w = 2 * beat_data_w;
    localparam int line_be_w   = 2 * beat_be_w;
    localparam int buf_idx_w   = 4;
    localparam int lcrd_cnt_w  = 4;

    // flit field offsets
    localparam int flit_data_lsb    = 0;
    localparam int flit_be_lsb      = flit_data_lsb + beat_data_w;
    localparam int flit_dataid_lsb  = flit_be_lsb + beat_be_w;
    localparam int flit_dbid_lsb    = flit_dataid_lsb + dataid_w;
    localparam int flit_resp_lsb    = flit_dbid_lsb + txn_id_w;
    localparam int flit_resperr_lsb = flit_resp_lsb + resp_w;
    localparam int flit_opcode_lsb  = flit_resperr_lsb + resperr_w;
    localparam int flit_homenid_lsb = flit_opcode_lsb + opcode_w;
    localparam int flit_txnid_lsb   = flit_homenid_lsb + node_id_w;
    localparam int flit_srcid_lsb   = flit_txnid_lsb + txn_id_w;
    localparam int flit_tgtid_lsb   = flit_srcid_lsb + node_id_w;
    localparam int flit_w           = flit_tgtid_lsb + node_id_w;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [node_id_w-1:0]   node_id_t;
    typedef logic [txn_id_w-1:0]    txn_id_t;
    typedef logic [opcode_w-1:0]    opcode_t;
    typedef logic [resp_w-1:0]      resp_t;
    typedef logic [resperr_w-1:0]   resperr_t;
    typedef logic [dataid_w-1:0]    dataid_t;
    typedef logic [beat_data_w-1:0] beat_data_t;
    typedef logic [beat_be_w-1:0]   beat_be_t;
    typedef logic [line_data_w-1:0] line_data_t;
    typedef logic [line_be_w-1:0]   line_be_t;
    typedef logic [buf_idx_w-1:0]   buf_idx_t;
    typedef logic [lcrd_cnt_w-1:0]  lcrd_cnt_t;
    typedef logic [flit_w-1:0]      flit_t;

    // bit 0 lower half pending, bit 1 upper half pending
    typedef logic [1:0] pend_t;

    typedef enum logic [1:0] {
        beat_idle = 2'd0,
        beat_low  = 2'd1,
        beat_high = 2'd2
    } beat_state_t;

    // ------------------------------
    // constants
    // ------------------------------
    localparam lcrd_cnt_t max_lcrd        = 4'd15;
    localparam node_id_t  home_node_id    = 7'h12;
    localparam opcode_t   opcode_compdata = 4'h4;
    localparam dataid_t   dataid_low      = 2'd0;
    localparam dataid_t   dataid_high     = 2'd2;

endpackage

// File: design/txdat_top.sv
//------------------------------
// transmit data channel of the home node
// holds up to two lines and sends their pending halves as credited flits
// first flit leaves two edges after the line is taken
// release report lines up with the last flit of each line
//------------------------------

`timescale 1ns/100ps

module txdat_top
    import txdat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_valid,
    output logic       line_ready,
    input  buf_idx_t   line_idx,
    input  node_id_t   line_tgtid,
    input  txn_id_t    line_txnid,
    input  opcode_t    line_opcode,
    input  resp_t      line_resp,
    input  resperr_t   line_resperr,
    input  txn_id_t    line_dbid,
    input  line_data_t line_data,
    input  line_be_t   line_be,
    input  pend_t      line_pend,
    input  logic       lcrdv,
    output logic       flitv,
    output flit_t      flit,
    output logic       release_valid,
    output buf_idx_t   release_idx
);

    logic       head_valid;
    node_id_t   head_tgtid;
    txn_id_t    head_txnid;
    opcode_t    head_opcode;
    resp_t      head_resp;
    resperr_t   head_resperr;
    txn_id_t    head_dbid;
    line_data_t head_data;
    line_be_t   head_be;
    pend_t      head_pend;
    logic       crd_avail;
    logic       beat_send;
    logic       beat_upper;
    logic       line_pop;

    txdat_line_buffer line_buffer_inst (
        .clk           (clk),
        .rst           (rst),
        .line_valid    (line_valid),
        .line_ready    (line_ready),
        .line_idx      (line_idx),
        .line_tgtid    (line_tgtid),
        .line_txnid    (line_txnid),
        .line_opcode   (line_opcode),
        .line_resp     (line_resp),
        .line_resperr  (line_resperr),
        .line_dbid     (line_dbid),
        .line_data     (line_data),
        .line_be       (line_be),
        .line_pend     (line_pend),
        .line_pop      (line_pop),
        .head_valid    (head_valid),
        .head_tgtid    (head_tgtid),
        .head_txnid    (head_txnid),
        .head_opcode   (head_opcode),
        .head_resp     (head_resp),
        .head_resperr  (head_resperr),
        .head_dbid     (head_dbid),
        .head_data     (head_data),
        .head_be       (head_be),
        .head_pend     (head_pend),
        .release_valid (release_valid),
        .release_idx   (release_idx)
    );

    txdat_beat_fsm beat_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head_pend  (head_pend),
        .crd_avail  (crd_avail),
        .beat_send  (beat_send),
        .beat_upper (beat_upper),
        .line_pop   (line_pop)
    );

    txdat_lcrd_counter lcrd_counter_inst (
        .clk       (clk),
        .rst       (rst),
        .lcrdv     (lcrdv),
        .beat_send (beat_send),
        .crd_avail (crd_avail)
    );

    txdat_flit_packer flit_packer_inst (
        .clk          (clk),
        .rst          (rst),
        .beat_send    (beat_send),
        .beat_upper   (beat_upper),
        .head_tgtid   (head_tgtid),
        .head_txnid   (head_txnid),
        .head_opcode  (head_opcode),
        .head_resp    (head_resp),
        .head_resperr (head_resperr),
        .head_dbid    (head_dbid),
        .head_data    (head_data),
        .head_be      (head_be),
        .flitv        (flitv),
        .flit         (flit)
    );

endmodule

// File: testbench/txdat_tb_checks.svh
//------------------------------
// compare tasks and stimulus lfsr for the txdat testbench
// included inside the testbench module, uses its error counter
// lfsr is 32-bit fibonacci, taps 32 22 2 1, one step per bit taken
//------------------------------

`ifndef TXDAT_TB_CHECKS_SVH
`define TXDAT_TB_CHECKS_SVH

task check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task check_idx(input string name, input buf_idx_t got, input buf_idx_t exp);
    if (got !== exp) begin
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

// new bit enters at bit 0
function logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

`endif

// File: testbench/txdat_tb.sv
//------------------------------
// testbench for the txdat channel
// one table row per line, credits granted alongside the push
// held rows get no credits and stay in the buffer for the next rows
// flits and releases are checked by a monitor in acceptance order
//------------------------------

`timescale 1ns/100ps

module txdat_tb
    import txdat_pkg::*;
();

    typedef struct packed {
        buf_idx_t idx;
        node_id_t tgtid;
        txn_id_t  txnid;
        opcode_t  opcode;
        resp_t    resp;
        resperr_t resperr;
        txn_id_t  dbid;
        pend_t    pend;
        int       credits;
        logic     hold;
        int       nflit;
    } row_t;

    localparam int num_rows   = 8;
    localparam int wait_limit = 60;

    logic       clk;
    logic       rst;
    logic       line_valid;
    logic       line_ready;
    buf_idx_t   line_idx;
    node_id_t   line_tgtid;
    txn_id_t    line_txnid;
    opcode_t    line_opcode;
    resp_t      line_resp;
    resperr_t   line_resperr;
    txn_id_t    line_dbid;
    line_data_t line_data;
    line_be_t   line_be;
    pend_t      line_pend;
    logic       lcrdv;
    logic       flitv;
    flit_t      flit;
    logic       release_valid;
    buf_idx_t   release_idx;

    row_t       rows [num_rows];
    logic [31:0] lfsr;
    line_data_t cur_data;
    line_be_t   cur_be;
    int         errors;
    int         lcrd_seen;
    int         flits_seen;
    int         exp_total;
    int         held;
    int         r;
    int         err_start;
    int         tests_bad;
    logic       aborted;
    flit_t      exp_flit_q [$];
    logic       exp_last_q [$];
    buf_idx_t   exp_idx_q [$];
    flit_t      mon_flit;
    logic       mon_last;

    `include "txdat_tb_checks.svh"

    txdat_top txdat_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // idx tgtid txnid opcode resp resperr dbid pend credits hold flits
    task load_table;
        rows[0] = '{4'h3, 7'h21, 12'h1a5, opcode_compdata, 3'd1, 2'd0, 12'h0c3, 2'b11, 2, 1'b0, 2};
        rows[1] = '{4'h5, 7'h0e, 12'h2f0, 4'h6, 3'd2, 2'd1, 12'h3d1, 2'b01, 1, 1'b0, 1};
        rows[2] = '{4'h9, 7'h7f, 12'hfff, opcode_compdata, 3'd7, 2'd3, 12'h800, 2'b10, 1, 1'b0, 1};
        rows[3] = '{4'h1, 7'h33, 12'h456, 4'h1, 3'd0, 2'd0, 12'h111, 2'b11, 0, 1'b1, 2};
        rows[4] = '{4'he, 7'h05, 12'h0ab, opcode_compdata, 3'd3, 2'd2, 12'h222, 2'b01, 0, 1'b1, 1};
        rows[5] = '{4'h7, 7'h40, 12'h9c9, 4'h7, 3'd5, 2'd0, 12'h333, 2'b10, 4, 1'b0, 1};
        rows[6] = '{4'hb, 7'h2a, 12'h777, 4'h8, 3'd4, 2'd1, 12'h444, 2'b11, 3, 1'b0, 2};
        rows[7] = '{4'h0, 7'h11, 12'h123, opcode_compdata, 3'd6, 2'd2, 12'h555, 2'b11, 1, 1'b0, 2};
    endtask

    task make_line;
        int k;
        for (k = 0; k < line_data_w; k++) begin
            lfsr = lfsr_step(lfsr);
            cur_data[k] = lfsr[0];
        end
        for (k = 0; k < line_be_w; k++) begin
            lfsr = lfsr_step(lfsr);
            cur_be[k] = lfsr[0];
        end
    endtask

    // field order from tgtid down to data
    function flit_t expected_flit(input row_t rw, input logic upper);
        beat_data_t data;
        beat_be_t   be;
        dataid_t    id;
        node_id_t   homenid;
        if (upper) begin
            data = cur_data[line_data_w-1:beat_data_w];
            be   = cur_be[line_be_w-1:beat_be_w];
            id   = dataid_high;
        end else begin
            data = cur_data[beat_data_w-1:0];
            be   = cur_be[beat_be_w-1:0];
            id   = dataid_low;
        end
        homenid = (rw.opcode == opcode_compdata) ? home_node_id : 7'h00;
        return {rw.tgtid, home_node_id, rw.txnid, homenid, rw.opcode,
                rw.resperr, rw.resp, rw.dbid, id, be, data};
    endfunction

    task queue_line(input int n);
        if (rows[n].pend[0]) begin
            exp_flit_q.push_back(expected_flit(rows[n], 1'b0));
            exp_last_q.push_back(!rows[n].pend[1]);
        end
        if (rows[n].pend[1]) begin
            exp_flit_q.push_back(expected_flit(rows[n], 1'b1));
            exp_last_q.push_back(1'b1);
        end
        exp_idx_q.push_back(rows[n].idx);
    endtask

    task grant_credits(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            lcrdv = 1'b1;
        end
        if (n != 0) begin
            @(negedge clk);
            lcrdv = 1'b0;
        end
    endtask

    task push_line(input int n);
        int   waited;
        logic was_low;
        @(negedge clk);
        line_idx     = rows[n].idx;
        line_tgtid   = rows[n].tgtid;
        line_txnid   = rows[n].txnid;
        line_opcode  = rows[n].opcode;
        line_resp    = rows[n].resp;
        line_resperr = rows[n].resperr;
        line_dbid    = rows[n].dbid;
        line_pend    = rows[n].pend;
        line_data    = cur_data;
        line_be      = cur_be;
        line_valid   = 1'b1;
        waited  = 0;
        was_low = 1'b0;
        while (!line_ready && waited < wait_limit) begin
            was_low = 1'b1;
            @(negedge clk);
            waited++;
        end
        // ready comes back together with the first release
        if (line_ready && was_low) begin
            check_bit("release_valid", release_valid, 1'b1);
        end
        if (!line_ready) begin
            $display("timeout: line_ready stayed low for row %0d", n);
            errors++;
            aborted = 1'b1;
        end
        @(negedge clk);
        line_valid = 1'b0;
    endtask

    task wait_drain(input int n);
        int waited;
        waited = 0;
        while (exp_flit_q.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_flit_q.size() != 0) begin
            $display("timeout: row %0d still has %0d flits outstanding", n, exp_flit_q.size());
            errors++;
            aborted = 1'b1;
        end else if (flits_seen != exp_total) begin
            $display("row %0d: %0d flits seen, %0d expected", n, flits_seen, exp_total);
            errors++;
        end
    endtask

    // no credit, so nothing may leave
    task observe_hold;
        repeat (6) begin
            @(negedge clk);
            check_bit("flitv", flitv, 1'b0);
            check_bit("line_ready", line_ready, held < 2);
        end
    endtask

    // ------------------------------
    // monitor
    // ------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            if (lcrdv) begin
                lcrd_seen++;
            end
            if (flitv) begin
                flits_seen++;
                if (flits_seen > lcrd_seen) begin
                    $display("flit %0d sent with only %0d credits granted", flits_seen, lcrd_seen);
                    errors++;
                end
                if (exp_flit_q.size() == 0) begin
                    $display("flitv high with no flit expected");
                    errors++;
                end else begin
                    mon_flit = exp_flit_q.pop_front();
                    mon_last = exp_last_q.pop_front();
                    check_flit("flit", flit, mon_flit);
                    check_bit("release_valid", release_valid, mon_last);
                    if (mon_last) begin
                        check_idx("release_idx", release_idx, exp_idx_q.pop_front());
                    end
                end
            end else if (release_valid) begin
                $display("release_valid high without a flit");
                errors++;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        line_valid   = 1'b0;
        line_idx     = '0;
        line_tgtid   = '0;
        line_txnid   = '0;
        line_opcode  = '0;
        line_resp    = '0;
        line_resperr = '0;
        line_dbid    = '0;
        line_data    = '0;
        line_be      = '0;
        line_pend    = '0;
        lcrdv        = 1'b0;
        errors       = 0;
        lcrd_seen    = 0;
        flits_seen   = 0;
        exp_total    = 0;
        held         = 0;
        tests_bad    = 0;
        aborted      = 1'b0;
        lfsr         = 32'h86d44758;
        load_table();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_bit("line_ready", line_ready, 1'b1);
        check_bit("flitv", flitv, 1'b0);
        check_bit("release_valid", release_valid, 1'b0);
        if (errors != 0) begin
            tests_bad++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");

        for (r = 0; r < num_rows && !aborted; r++) begin
            err_start = errors;
            make_line();
            queue_line(r);
            exp_total += rows[r].nflit;
            fork
                grant_credits(rows[r].credits);
                push_line(r);
            join
            if (rows[r].hold) begin
                held++;
                observe_hold();
            end else begin
                wait_drain(r);
                held = 0;
            end
            if (errors != err_start) begin
                tests_bad++;
            end
            $display("test %0d idx %h pend %b: %s", r, rows[r].idx, rows[r].pend,
                     (errors == err_start) ? "ok" : "failed");
        end

        if (!aborted && lcrd_seen != flits_seen) begin
            $display("%0d credits granted but %0d flits sent", lcrd_seen, flits_seen);
            errors++;
        end
        $display("tests %0d, failed %0d, errors %0d, flits %0d", num_rows + 1, tests_bad,
                 errors, flits_seen);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
